// File: filelist.f
+incdir+.
exu_pkg.sv
exu_issue_if.sv
exu_stage_reg.sv
exu_alu.sv
exu_branch_unit.sv
exu_csr_file.sv
exu_writeback.sv
exu_top.sv
exu_assert.sv
tb_exu_checker.sv
tb_exu.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module tb_exu -o sim_exu &&
./obj_dir/sim_exu | tee /dev/stderr | grep -q ">>> PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// File: tb_exu.sv
`timescale 1ns/1ps

// free running clock
module tb_clk_gen #(parameter int PERIOD = 8) (
    output logic clk
);
    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;
endmodule

module tb_exu;
    import exu_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int N_INSTR = 400;
    // twice reset plus instructions plus margin
    localparam int CYCLE_LIMIT = 2 * (RESET_CYCLES + N_INSTR) + 100;

    logic      clk;
    logic      rst;
    logic      issue_valid;
    exu_op_t   op;
    xlen_t     pc;
    inst_t     inst;
    xlen_t     src1;
    xlen_t     src2;
    xlen_t     alu_a;
    xlen_t     alu_b;
    alu_mode_t alu_mode;
    logic      pc_update;
    xlen_t     dnpc;
    xlen_t     wb_pc;
    inst_t     wb_inst;
    logic      reg_wen;
    logic [4:0] reg_rd;
    xlen_t     reg_wdata;

    integer seed = 32'hc5d6;
    integer n_issued = 0;
    integer cycles = 0;
    alu_mode_t modes [10] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
                              ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA};

    tb_clk_gen #(.PERIOD(8)) u_clk (.clk(clk));

    exu_top UUT (
        .clk(clk), .rst(rst), .issue_valid(issue_valid), .op(op), .pc(pc), .inst(inst),
        .src1(src1), .src2(src2), .alu_a(alu_a), .alu_b(alu_b), .alu_mode(alu_mode),
        .pc_update(pc_update), .dnpc(dnpc), .wb_pc(wb_pc), .wb_inst(wb_inst),
        .reg_wen(reg_wen), .reg_rd(reg_rd), .reg_wdata(reg_wdata)
    );

    tb_exu_checker u_checker (.*);

    // ********************
    // stimulus helpers
    // ********************
    task automatic issue(input logic v, input exu_op_t o, input xlen_t p, input inst_t i,
                         input xlen_t s1, input xlen_t s2, input xlen_t a, input xlen_t b,
                         input alu_mode_t m);
        @(posedge clk);
        #1;
        issue_valid = v;
        op = o;
        pc = p;
        inst = i;
        src1 = s1;
        src2 = s2;
        alu_a = a;
        alu_b = b;
        alu_mode = m;
        n_issued = n_issued + 1;
    endtask

    // csr instruction word with rd = x5
    function automatic inst_t csr_inst(input logic [11:0] addr);
        return {addr, 5'd0, 3'b010, 5'd5, 7'h73};
    endfunction

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic random_instr();
        integer sel;
        xlen_t p;
        xlen_t s1;
        xlen_t s2;
        inst_t i;
        logic [11:0] csr_addrs [5];
        csr_addrs = '{12'h300, 12'h305, 12'h341, 12'h342, 12'h7c0};
        sel = {$random(seed)} % 16;
        p = rand64() & ~64'd3;
        s1 = rand64();
        s2 = rand64();
        i = $random(seed);
        // equal and sign-flipped operands for branch edges
        if (sel >= 8 && sel <= 10 && {$random(seed)} % 3 == 0)
            s2 = s1;
        else if (sel >= 8 && sel <= 10 && {$random(seed)} % 3 == 0)
            s2 = s1 ^ 64'h8000_0000_0000_0000;
        if (sel <= 4)
            issue(1'b1, OP_ALU, p, i, s1, s2, s1, s2, modes[{$random(seed)} % 10]);
        else if (sel == 5)
            issue(1'b1, OP_LUI, p, i, s1, s2, s1, s2, ALU_ADD);
        else if (sel == 6)
            issue(1'b1, OP_JAL, p, i, s1, s2, p, {{44{i[31]}}, i[31:12]}, ALU_ADD);
        else if (sel == 7)
            issue(1'b1, OP_JALR, p, i, s1, s2, s1, {{52{i[31]}}, i[31:20]}, ALU_ADD);
        else if (sel <= 10) begin
            case ({$random(seed)} % 6)
                0: issue(1'b1, OP_BEQ, p, i, s1, s2, s1, s2, ALU_SUB);
                1: issue(1'b1, OP_BNE, p, i, s1, s2, s1, s2, ALU_SUB);
                2: issue(1'b1, OP_BLT, p, i, s1, s2, s1, s2, ALU_SUB);
                3: issue(1'b1, OP_BGE, p, i, s1, s2, s1, s2, ALU_SUB);
                4: issue(1'b1, OP_BLTU, p, i, s1, s2, s1, s2, ALU_SUB);
                default: issue(1'b1, OP_BGEU, p, i, s1, s2, s1, s2, ALU_SUB);
            endcase
        end else if (sel <= 12) begin
            i = {csr_addrs[{$random(seed)} % 5], i[19:0]};
            issue(1'b1, (sel == 11) ? OP_CSRRW : OP_CSRRS, p, i, s1, s2, s1, s2, ALU_ADD);
        end else if (sel == 13)
            issue(1'b1, OP_NOP, p, i, s1, s2, s1, s2, ALU_ADD);
        else if (sel == 14)
            // bubble with a noise payload
            issue(1'b0, OP_ALU, p, i, s1, s2, s1, s2, ALU_ADD);
        else
            issue(1'b1, i[0] ? OP_MRET : OP_ECALL, p, i, s1, s2, s1, s2, ALU_ADD);
    endtask

    // ********************
    // main sequence
    // ********************
    initial begin
        rst = 1'b1;
        issue_valid = 1'b0;
        op = OP_NOP;
        pc = 64'd0;
        inst = 32'd0;
        src1 = 64'd0;
        src2 = 64'd0;
        alu_a = 64'd0;
        alu_b = 64'd0;
        alu_mode = ALU_ADD;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // mstatus reset value first
        issue(1'b1, OP_CSRRS, 64'h8000_0000, csr_inst(12'h300), 0, 0, 0, 0, ALU_ADD);
        // mtvec write then set bits and read back
        issue(1'b1, OP_CSRRW, 64'h8000_0004, csr_inst(12'h305), 64'h8000_1000, 0, 0, 0,
              ALU_ADD);
        issue(1'b1, OP_CSRRS, 64'h8000_0008, csr_inst(12'h305), 64'h4, 0, 0, 0, ALU_ADD);
        issue(1'b1, OP_CSRRS, 64'h8000_000c, csr_inst(12'h305), 0, 0, 0, 0, ALU_ADD);
        // trap round trip
        issue(1'b1, OP_ECALL, 64'h8000_0040, 32'h0000_0073, 0, 0, 0, 0, ALU_ADD);
        issue(1'b1, OP_CSRRS, 64'h8000_1004, csr_inst(12'h342), 0, 0, 0, 0, ALU_ADD);
        issue(1'b1, OP_CSRRS, 64'h8000_1008, csr_inst(12'h341), 0, 0, 0, 0, ALU_ADD);
        issue(1'b1, OP_MRET, 64'h8000_100c, 32'h3020_0073, 0, 0, 0, 0, ALU_ADD);
        // idle slots
        issue(1'b0, OP_ALU, 64'h8000_0044, 32'h0010_0093, 1, 2, 1, 2, ALU_ADD);
        issue(1'b1, OP_NOP, 64'h8000_0048, 32'h0000_0013, 1, 2, 1, 2, ALU_ADD);

        while (n_issued < N_INSTR)
            random_instr();
        issue(1'b0, OP_NOP, 64'd0, 32'd0, 0, 0, 0, 0, ALU_ADD);
        repeat (2) @(posedge clk);

        $display("checks %0d, errors %0d, assertion failures %0d", u_checker.check_count,
                 u_checker.error_count, UUT.u_assert.fail_count);
        if (u_checker.error_count == 0 && UUT.u_assert.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // hang guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule

// File: tb_exu_checker.sv
`timescale 1ns/1ps

// watches the stage inputs, predicts and compares one cycle later
module tb_exu_checker (
    input logic                clk,
    input logic                rst,
    input logic                issue_valid,
    input exu_pkg::exu_op_t    op,
    input exu_pkg::xlen_t      pc,
    input exu_pkg::inst_t      inst,
    input exu_pkg::xlen_t      src1,
    input exu_pkg::xlen_t      src2,
    input exu_pkg::xlen_t      alu_a,
    input exu_pkg::xlen_t      alu_b,
    input exu_pkg::alu_mode_t  alu_mode,
    input logic                pc_update,
    input exu_pkg::xlen_t      dnpc,
    input exu_pkg::xlen_t      wb_pc,
    input exu_pkg::inst_t      wb_inst,
    input logic                reg_wen,
    input logic [4:0]          reg_rd,
    input exu_pkg::xlen_t      reg_wdata
);
    import exu_pkg::*;

    typedef struct packed {
        logic  pc_update;
        xlen_t dnpc;
        logic  reg_wen;
        xlen_t reg_wdata;
    } exp_t;

    integer check_count = 0;
    integer error_count = 0;

    // csr model
    xlen_t m_mstatus;
    xlen_t m_mtvec;
    xlen_t m_mepc;
    xlen_t m_mcause;

    // expectation for the current output cycle
    logic  pend = 1'b0;
    logic  p_valid;
    exp_t  p_exp;
    xlen_t p_pc;
    inst_t p_inst;

    // ********************
    // reference model
    // ********************
    function automatic xlen_t alu_ref(input alu_mode_t m, input xlen_t a, input xlen_t b);
        case (m)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            ALU_SLTU: return (a < b) ? 64'd1 : 64'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[5:0];
            ALU_SRL:  return a >> b[5:0];
            ALU_SRA:  return xlen_t'($signed(a) >>> b[5:0]);
            default:  return 64'd0;
        endcase
    endfunction

    // unknown addresses read zero
    function automatic xlen_t csr_ref(input logic [11:0] addr);
        case (addr)
            12'h300: return m_mstatus;
            12'h305: return m_mtvec;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            default: return 64'd0;
        endcase
    endfunction

    function automatic exp_t exu_model(input logic v, input exu_op_t o, input xlen_t p,
                                       input inst_t i, input xlen_t s1, input xlen_t s2,
                                       input xlen_t a, input xlen_t b, input alu_mode_t m);
        exp_t  e;
        xlen_t res;
        xlen_t seq;
        xlen_t tgt;
        logic  taken;
        res = alu_ref(m, a, b);
        seq = p + 64'd4;
        // b-type offset
        tgt = p + {{51{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        taken = 1'b0;
        e.pc_update = v && (o != OP_NOP);
        e.reg_wen = 1'b0;
        e.reg_wdata = 64'd0;
        e.dnpc = seq;
        case (o)
            OP_BEQ:  taken = (res == 64'd0);
            OP_BNE:  taken = (res != 64'd0);
            OP_BLT:  taken = res[63];
            OP_BGE:  taken = !res[63];
            OP_BLTU: taken = (s1 < s2);
            OP_BGEU: taken = (s1 >= s2);
            default: taken = 1'b0;
        endcase
        if (taken)
            e.dnpc = tgt;
        case (o)
            OP_ALU: begin
                e.reg_wen = v;
                e.reg_wdata = res;
            end
            OP_LUI: begin
                e.reg_wen = v;
                e.reg_wdata = {{32{i[31]}}, i[31:12], 12'b0};
            end
            OP_JAL, OP_JALR: begin
                e.reg_wen = v;
                e.reg_wdata = seq;
                e.dnpc = (o == OP_JALR) ? {res[63:1], 1'b0} : res;
            end
            OP_CSRRW, OP_CSRRS: begin
                e.reg_wen = v;
                e.reg_wdata = csr_ref(i[31:20]);
            end
            OP_ECALL: e.dnpc = m_mtvec;
            OP_MRET:  e.dnpc = m_mepc;
            default: ;
        endcase
        return e;
    endfunction

    // ********************
    // capture and csr update
    // ********************
    always @(posedge clk) begin
        xlen_t old;
        xlen_t nv;
        if (rst) begin
            pend = 1'b0;
            m_mstatus = 64'h0000_000A_0000_1800;
            m_mtvec = 64'd0;
            m_mepc = 64'd0;
            m_mcause = 64'd0;
        end else begin
            pend = 1'b1;
            p_valid = issue_valid;
            p_pc = pc;
            p_inst = inst;
            p_exp = exu_model(issue_valid, op, pc, inst, src1, src2, alu_a, alu_b, alu_mode);
            if (issue_valid && op == OP_ECALL) begin
                m_mepc = pc;
                m_mcause = 64'd11;
            end else if (issue_valid && (op == OP_CSRRW || op == OP_CSRRS)) begin
                old = csr_ref(inst[31:20]);
                nv = (op == OP_CSRRW) ? src1 : (old | src1);
                case (inst[31:20])
                    12'h300: m_mstatus = nv;
                    12'h305: m_mtvec = nv;
                    12'h341: m_mepc = nv;
                    12'h342: m_mcause = nv;
                    default: ;
                endcase
            end
        end
    end

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        check_count = check_count + 1;
        if (exp !== act) begin
            error_count = error_count + 1;
            $display("CHECK FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    // ********************
    // compare mid-cycle, outputs settled
    // ********************
    always @(negedge clk) begin
        if (pend) begin
            check_val("pc_update", {63'd0, p_exp.pc_update}, {63'd0, pc_update});
            check_val("reg_wen", {63'd0, p_exp.reg_wen}, {63'd0, reg_wen});
            if (p_valid) begin
                check_val("wb_pc", p_pc, wb_pc);
                check_val("wb_inst", {32'd0, p_inst}, {32'd0, wb_inst});
                if (p_exp.pc_update)
                    check_val("dnpc", p_exp.dnpc, dnpc);
                if (p_exp.reg_wen) begin
                    check_val("reg_rd", {59'd0, p_inst[11:7]}, {59'd0, reg_rd});
                    check_val("reg_wdata", p_exp.reg_wdata, reg_wdata);
                end
            end
        end
    end

endmodule

// File: exu_assert.sv
`timescale 1ns/1ps

// protocol properties on the execute stage outputs
module exu_assert (
    input logic             clk,
    input logic             rst,
    input logic             issue_valid,
    input exu_pkg::exu_op_t op,
    input logic             pc_update,
    input logic             reg_wen,
    input exu_pkg::xlen_t   dnpc
);
    import exu_pkg::*;

    // number of property failures
    integer fail_count = 0;

    // a write-back only comes with a real instruction
    a_wen_needs_update: assert property (@(posedge clk) disable iff (rst)
        reg_wen |-> pc_update)
        else begin
            $error("reg_wen high without pc_update");
            fail_count = fail_count + 1;
        end

    // stage register is empty right after reset
    a_quiet_after_reset: assert property (@(posedge clk)
        rst |=> !pc_update)
        else begin
            $error("pc_update high in the cycle after reset");
            fail_count = fail_count + 1;
        end

    // jalr target is never odd
    a_jalr_even: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && op == OP_JALR) |=> !dnpc[0])
        else begin
            $error("jalr target has bit 0 set");
            fail_count = fail_count + 1;
        end

endmodule

bind exu_top exu_assert u_assert (
    .clk(clk), .rst(rst), .issue_valid(issue_valid), .op(op),
    .pc_update(pc_update), .reg_wen(reg_wen), .dnpc(dnpc)
);

// File: exu_top.sv
`timescale 1ns/1ps

// execute stage top
module exu_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  exu_pkg::exu_op_t   op,
    input  exu_pkg::xlen_t     pc,
    input  exu_pkg::inst_t     inst,
    input  exu_pkg::xlen_t     src1,
    input  exu_pkg::xlen_t     src2,
    input  exu_pkg::xlen_t     alu_a,
    input  exu_pkg::xlen_t     alu_b,
    input  exu_pkg::alu_mode_t alu_mode,
    output logic               pc_update,
    output exu_pkg::xlen_t     dnpc,
    output exu_pkg::xlen_t     wb_pc,
    output exu_pkg::inst_t     wb_inst,
    output logic               reg_wen,
    output logic [4:0]         reg_rd,
    output exu_pkg::xlen_t     reg_wdata
);
    import exu_pkg::*;

    // unit to unit wires
    xlen_t alu_result;
    xlen_t mtvec;
    xlen_t mepc;
    xlen_t csr_rdata;

    // ********************
    // pipeline register
    // ********************
    exu_issue_if issue_bus ();

    exu_stage_reg u_stage_reg (
        .clk(clk), .rst(rst), .issue_valid(issue_valid),
        .op(op), .pc(pc), .inst(inst), .src1(src1), .src2(src2),
        .alu_a(alu_a), .alu_b(alu_b), .alu_mode(alu_mode), .iss(issue_bus.stage)
    );

    // ********************
    // execute units
    // ********************
    exu_alu u_alu (.iss(issue_bus.unit), .alu_result(alu_result));

    exu_branch_unit u_branch (
        .iss(issue_bus.unit), .alu_result(alu_result), .mtvec(mtvec), .mepc(mepc),
        .dnpc(dnpc), .pc_update(pc_update)
    );

    // csrs live next to the pc and write-back logic they feed
    exu_csr_file u_csr (
        .clk(clk), .rst(rst), .iss(issue_bus.unit),
        .csr_rdata(csr_rdata), .mtvec(mtvec), .mepc(mepc)
    );

    exu_writeback u_wb (
        .iss(issue_bus.unit), .alu_result(alu_result), .csr_rdata(csr_rdata),
        .reg_wen(reg_wen), .reg_rd(reg_rd), .reg_wdata(reg_wdata)
    );

    // pc and inst passed on to write-back stage
    assign wb_pc   = issue_bus.pc;
    assign wb_inst = issue_bus.inst;

endmodule

// File: exu_writeback.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

// register file write port selection
module exu_writeback (
    exu_issue_if.unit       iss,
    input  exu_pkg::xlen_t  alu_result,
    input  exu_pkg::xlen_t  csr_rdata,
    output logic            reg_wen,
    output logic [4:0]      reg_rd,
    output exu_pkg::xlen_t  reg_wdata
);
    import exu_pkg::*;

    // u-type immediate, sign extended to xlen
    xlen_t imm_u;

    assign imm_u  = {{(`XLEN-32){iss.inst[31]}}, iss.inst[31:12], 12'b0};
    assign reg_rd = iss.inst[11:7];

    always_comb begin
        reg_wen = 1'b0;
        unique case (iss.op)
            OP_ALU:             reg_wdata = alu_result;
            OP_LUI:             reg_wdata = imm_u;
            // link address
            OP_JAL, OP_JALR:    reg_wdata = iss.pc + `PC_STEP;
            // rd gets the value before the write
            OP_CSRRW, OP_CSRRS: reg_wdata = csr_rdata;
            default:            reg_wdata = '0;
        endcase
        // only ops that produce a result write back
        unique case (iss.op)
            OP_ALU, OP_LUI, OP_JAL, OP_JALR, OP_CSRRW, OP_CSRRS: reg_wen = iss.valid;
            default:                                             reg_wen = 1'b0;
        endcase
    end

endmodule

// File: exu_csr_file.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

// machine csrs: mtvec, mepc, mcause, mstatus
module exu_csr_file (
    input  logic            clk,
    input  logic            rst,
    exu_issue_if.unit       iss,
    output exu_pkg::xlen_t  csr_rdata,
    output exu_pkg::xlen_t  mtvec,
    output exu_pkg::xlen_t  mepc
);
    import exu_pkg::*;

    xlen_t     mcause;
    xlen_t     mstatus;
    csr_addr_t csr_addr;
    xlen_t     csr_wdata;
    logic      csr_wen;

    assign csr_addr = iss.inst[31:20];

    // ********************
    // read mux, old value
    // ********************
    always_comb begin
        unique case (csr_addr)
            `CSR_MSTATUS: csr_rdata = mstatus;
            `CSR_MTVEC:   csr_rdata = mtvec;
            `CSR_MEPC:    csr_rdata = mepc;
            `CSR_MCAUSE:  csr_rdata = mcause;
            // unimplemented csrs read zero
            default:      csr_rdata = '0;
        endcase
    end

    // csrrw replaces, csrrs sets bits
    assign csr_wen   = (iss.op == OP_CSRRW) || (iss.op == OP_CSRRS);
    assign csr_wdata = (iss.op == OP_CSRRW) ? iss.src1 : (csr_rdata | iss.src1);

    // ********************
    // write and trap update
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
            mstatus <= `MSTATUS_RESET;
        end else if (iss.valid) begin
            if (iss.op == OP_ECALL) begin
                // trap entry saves the faulting pc
                mepc   <= iss.pc;
                mcause <= `CAUSE_ECALL_M;
            end else if (csr_wen) begin
                unique case (csr_addr)
                    `CSR_MSTATUS: mstatus <= csr_wdata;
                    `CSR_MTVEC:   mtvec   <= csr_wdata;
                    `CSR_MEPC:    mepc    <= csr_wdata;
                    `CSR_MCAUSE:  mcause  <= csr_wdata;
                    default:      ;
                endcase
            end
        end
    end

endmodule

// File: exu_branch_unit.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

// next pc selection for jumps, branches and traps
module exu_branch_unit (
    exu_issue_if.unit       iss,
    input  exu_pkg::xlen_t  alu_result,
    input  exu_pkg::xlen_t  mtvec,
    input  exu_pkg::xlen_t  mepc,
    output exu_pkg::xlen_t  dnpc,
    output logic            pc_update
);
    import exu_pkg::*;

    xlen_t snpc;
    xlen_t imm_b;
    xlen_t br_target;

    assign snpc = iss.pc + `PC_STEP;

    // b-type immediate, sign extended, bit 0 always zero
    assign imm_b = {{(`XLEN-13){iss.inst[31]}}, iss.inst[31], iss.inst[7],
                    iss.inst[30:25], iss.inst[11:8], 1'b0};
    assign br_target = iss.pc + imm_b;

    always_comb begin
        unique case (iss.op)
            OP_JAL:   dnpc = alu_result;
            // jalr drops bit 0 of the sum
            OP_JALR:  dnpc = {alu_result[`XLEN-1:1], 1'b0};
            // eq/ne look at a - b from the alu
            OP_BEQ:   dnpc = (alu_result == '0) ? br_target : snpc;
            OP_BNE:   dnpc = (alu_result != '0) ? br_target : snpc;
            // signed compare via the sign of a - b
            OP_BLT:   dnpc = alu_result[`XLEN-1] ? br_target : snpc;
            OP_BGE:   dnpc = !alu_result[`XLEN-1] ? br_target : snpc;
            OP_BLTU:  dnpc = (iss.src1 < iss.src2) ? br_target : snpc;
            OP_BGEU:  dnpc = (iss.src1 >= iss.src2) ? br_target : snpc;
            // trap entry and return
            OP_ECALL: dnpc = mtvec;
            OP_MRET:  dnpc = mepc;
            default:  dnpc = snpc;
        endcase
    end

    assign pc_update = iss.valid && (iss.op != OP_NOP);

endmodule

// File: exu_alu.sv
`timescale 1ns/1ps

// integer alu, operands already picked by the decoder
module exu_alu (
    exu_issue_if.unit       iss,
    output exu_pkg::xlen_t  alu_result
);
    import exu_pkg::*;

    // shift amount, rv64 uses six bits
    logic [5:0] shamt;

    assign shamt = iss.alu_b[5:0];

    always_comb begin
        unique case (iss.alu_mode)
            ALU_ADD:  alu_result = iss.alu_a + iss.alu_b;
            ALU_SUB:  alu_result = iss.alu_a - iss.alu_b;
            // set-less-than gives 0 or 1
            ALU_SLT:  alu_result = xlen_t'($signed(iss.alu_a) < $signed(iss.alu_b));
            ALU_SLTU: alu_result = xlen_t'(iss.alu_a < iss.alu_b);
            ALU_AND:  alu_result = iss.alu_a & iss.alu_b;
            ALU_OR:   alu_result = iss.alu_a | iss.alu_b;
            ALU_XOR:  alu_result = iss.alu_a ^ iss.alu_b;
            ALU_SLL:  alu_result = iss.alu_a << shamt;
            ALU_SRL:  alu_result = iss.alu_a >> shamt;
            // arithmetic, sign bit fills
            ALU_SRA:  alu_result = xlen_t'($signed(iss.alu_a) >>> shamt);
            default:  alu_result = '0;
        endcase
    end

endmodule

// File: exu_stage_reg.sv
`timescale 1ns/1ps

// decode to execute pipeline register
module exu_stage_reg (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  exu_pkg::exu_op_t   op,
    input  exu_pkg::xlen_t     pc,
    input  exu_pkg::inst_t     inst,
    input  exu_pkg::xlen_t     src1,
    input  exu_pkg::xlen_t     src2,
    input  exu_pkg::xlen_t     alu_a,
    input  exu_pkg::xlen_t     alu_b,
    input  exu_pkg::alu_mode_t alu_mode,
    exu_issue_if.stage         iss
);
    import exu_pkg::*;

    // ********************
    // valid bit
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            iss.valid <= 1'b0;
        end else begin
            // a bubble clears valid, payload is don't care
            iss.valid <= issue_valid;
        end
    end

    // ********************
    // payload, loaded every edge
    // ********************
    always_ff @(posedge clk) begin
        iss.op       <= op;
        iss.pc       <= pc;
        iss.inst     <= inst;
        iss.src1     <= src1;
        iss.src2     <= src2;
        iss.alu_a    <= alu_a;
        iss.alu_b    <= alu_b;
        iss.alu_mode <= alu_mode;
    end

endmodule

// File: exu_issue_if.sv
`timescale 1ns/1ps

// registered instruction bundle, valid qualifies everything
interface exu_issue_if;
    import exu_pkg::*;

    logic      valid;
    exu_op_t   op;
    xlen_t     pc;
    inst_t     inst;
    xlen_t     src1;
    xlen_t     src2;
    xlen_t     alu_a;
    xlen_t     alu_b;
    alu_mode_t alu_mode;

    // driven by the stage register
    modport stage (output valid, op, pc, inst, src1, src2, alu_a, alu_b, alu_mode);
    // read by the execute units
    modport unit (input valid, op, pc, inst, src1, src2, alu_a, alu_b, alu_mode);

endinterface

// File: exu_pkg.sv
`include "exu_defines.svh"

package exu_pkg;

    // data word and pc
    typedef logic [`XLEN-1:0] xlen_t;
    // raw instruction word
    typedef logic [`ILEN-1:0] inst_t;
    // csr index from inst[31:20]
    typedef logic [11:0] csr_addr_t;

    // decoded operation class
    typedef enum logic [4:0] {
        OP_NOP   = 5'd0,
        OP_ALU   = 5'd1,
        OP_LUI   = 5'd2,
        OP_JAL   = 5'd3,
        OP_JALR  = 5'd4,
        OP_BEQ   = 5'd5,
        OP_BNE   = 5'd6,
        OP_BLT   = 5'd7,
        OP_BGE   = 5'd8,
        OP_BLTU  = 5'd9,
        OP_BGEU  = 5'd10,
        OP_CSRRW = 5'd11,
        OP_CSRRS = 5'd12,
        OP_ECALL = 5'd13,
        OP_MRET  = 5'd14
    } exu_op_t;

    // alu modes, codes as used by the decoder
    typedef enum logic [7:0] {
        ALU_ADD  = 8'd0,
        ALU_SUB  = 8'd1,
        ALU_SLT  = 8'd2,
        ALU_SLTU = 8'd3,
        ALU_AND  = 8'd4,
        ALU_OR   = 8'd6,
        ALU_XOR  = 8'd7,
        ALU_SLL  = 8'd8,
        ALU_SRL  = 8'd9,
        ALU_SRA  = 8'd10
    } alu_mode_t;

endpackage

// File: exu_defines.svh
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// ********************
// datapath widths
// ********************
`define XLEN 64
`define ILEN 32

// ********************
// machine csr addresses
// ********************
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// mpp = machine, plus the uxl/sxl field
`define MSTATUS_RESET 64'h0000_000A_0000_1800

// environment call from m-mode
`define CAUSE_ECALL_M 64'd11

// sequential fetch step
`define PC_STEP 64'd4

`endif
